//--- xreg_pkg.sv
// Host register block definitions
`default_nettype none

package xreg_pkg;

localparam int WORD_W       = 16;       // data and address width
localparam int BYTE_W       = 8;        // host bus byte
localparam int REG_NUM_W    = 4;
localparam int NUM_REGS     = 16;       // width of one-hot select
localparam int INTR_W       = 4;        // interrupt sources
localparam int WRMASK_W     = 4;        // vram nibble write mask

localparam logic [WRMASK_W-1:0] WRMASK_RESET = '1;     // all nibbles enabled

// kept short so a tick passes quickly in simulation
localparam int TIMER_DIV    = 100;      // clocks per tick less one
localparam int TIMER_FRAC_W = 12;       // divider counter width

localparam logic [REG_NUM_W-1:0] XM_SYS_CTRL = 4'h0;   // mem_wait, write mask
localparam logic [REG_NUM_W-1:0] XM_INT_CTRL = 4'h1;   // mask, clear, status
localparam logic [REG_NUM_W-1:0] XM_TIMER    = 4'h2;   // free-running ticks
localparam logic [REG_NUM_W-1:0] XM_RD_XADDR = 4'h3;
localparam logic [REG_NUM_W-1:0] XM_WR_XADDR = 4'h4;
localparam logic [REG_NUM_W-1:0] XM_XDATA    = 4'h5;
localparam logic [REG_NUM_W-1:0] XM_RD_INCR  = 4'h6;
localparam logic [REG_NUM_W-1:0] XM_RD_ADDR  = 4'h7;
localparam logic [REG_NUM_W-1:0] XM_WR_INCR  = 4'h8;
localparam logic [REG_NUM_W-1:0] XM_WR_ADDR  = 4'h9;
localparam logic [REG_NUM_W-1:0] XM_DATA     = 4'hA;
localparam logic [REG_NUM_W-1:0] XM_DATA_2   = 4'hB;   // alias of DATA

// 12 to 15 unused and read as the vram data latch

endpackage

`default_nettype wire

//--- reg_ctrl.sv
// Register decode and system registers
`default_nettype none
`timescale 1ns/100ps

module reg_ctrl (
    input  wire logic                               clk,
    input  wire logic                               reset_i,
    input  wire logic                               bus_write_strobe_i,
    input  wire logic                               bus_read_strobe_i,
    input  wire logic [xreg_pkg::REG_NUM_W-1:0]     bus_reg_num_i,
    input  wire logic                               bus_bytesel_i,      // 0 even, 1 odd
    input  wire logic [xreg_pkg::BYTE_W-1:0]        bus_data_i,
    input  wire logic                               vram_busy_i,
    input  wire logic                               xr_busy_i,
    input  wire logic [xreg_pkg::WORD_W-1:0]        vram_word_i,
    input  wire logic [xreg_pkg::WORD_W-1:0]        xr_word_i,
    input  wire logic [xreg_pkg::WORD_W-1:0]        timer_word_i,
    input  wire logic [xreg_pkg::INTR_W-1:0]        intr_status_i,
    output logic      [xreg_pkg::NUM_REGS-1:0]      reg_sel_o,
    output logic                                    wr_even_o,
    output logic                                    wr_odd_o,
    output logic                                    rd_even_o,
    output logic                                    rd_odd_o,
    output logic      [xreg_pkg::BYTE_W-1:0]        byte_o,
    output logic      [xreg_pkg::BYTE_W-1:0]        bus_data_o,
    output logic      [xreg_pkg::WRMASK_W-1:0]      wrmask_o,
    output logic      [xreg_pkg::INTR_W-1:0]        intr_mask_o,
    output logic      [xreg_pkg::INTR_W-1:0]        intr_clear_o
);

logic                           mem_wait;       // any memory access in flight
logic [xreg_pkg::WORD_W-1:0]    rd_word;        // word picked for read-back

assign reg_sel_o = {{(xreg_pkg::NUM_REGS-1){1'b0}}, 1'b1} << bus_reg_num_i;

assign wr_even_o = bus_write_strobe_i & ~bus_bytesel_i;
assign wr_odd_o  = bus_write_strobe_i &  bus_bytesel_i;
assign rd_even_o = bus_read_strobe_i  & ~bus_bytesel_i;
assign rd_odd_o  = bus_read_strobe_i  &  bus_bytesel_i;
assign byte_o    = bus_data_i;

assign mem_wait  = vram_busy_i | xr_busy_i;

always_ff @(posedge clk) begin
    if (reset_i) begin
        wrmask_o        <= xreg_pkg::WRMASK_RESET;
        intr_mask_o     <= '0;
        intr_clear_o    <= '0;
    end else begin
        intr_clear_o    <= '0;                  // single cycle pulse
        if (wr_odd_o && reg_sel_o[xreg_pkg::XM_SYS_CTRL]) begin
            wrmask_o        <= bus_data_i[xreg_pkg::WRMASK_W-1:0];
        end
        if (wr_even_o && reg_sel_o[xreg_pkg::XM_INT_CTRL]) begin
            intr_mask_o     <= bus_data_i[xreg_pkg::INTR_W-1:0];
        end
        if (wr_odd_o && reg_sel_o[xreg_pkg::XM_INT_CTRL]) begin
            intr_clear_o    <= bus_data_i[xreg_pkg::INTR_W-1:0];
        end
    end
end

// unused status bits read as zero
always_comb begin
    case (bus_reg_num_i)
        xreg_pkg::XM_SYS_CTRL:
            rd_word = {mem_wait, 7'b0, 4'b0, wrmask_o};
        xreg_pkg::XM_INT_CTRL:
            rd_word = {4'b0, intr_mask_o, 4'b0, intr_status_i};
        xreg_pkg::XM_TIMER:
            rd_word = timer_word_i;
        xreg_pkg::XM_RD_XADDR,
        xreg_pkg::XM_WR_XADDR,
        xreg_pkg::XM_XDATA:
            rd_word = xr_word_i;                // xr_port muxes its own
        default:
            rd_word = vram_word_i;              // incl. unused slots
    endcase
end

assign bus_data_o = bus_bytesel_i ? rd_word[7:0] : rd_word[15:8];

endmodule

`default_nettype wire

//--- vram_port.sv
// VRAM address registers and access sequencing
`default_nettype none
`timescale 1ns/100ps

module vram_port (
    input  wire logic                               clk,
    input  wire logic                               reset_i,
    input  wire logic [xreg_pkg::NUM_REGS-1:0]      reg_sel_i,
    input  wire logic                               wr_even_i,
    input  wire logic                               wr_odd_i,
    input  wire logic                               rd_odd_i,
    input  wire logic [xreg_pkg::BYTE_W-1:0]        byte_i,
    input  wire logic                               vram_ack_i,
    input  wire logic [xreg_pkg::WORD_W-1:0]        vram_data_i,
    output logic                                    vram_sel_o,
    output logic                                    vram_wr_o,
    output logic      [xreg_pkg::WORD_W-1:0]        vram_addr_o,
    output logic      [xreg_pkg::WORD_W-1:0]        vram_data_o,
    output logic                                    vram_busy_o,
    output logic      [xreg_pkg::WORD_W-1:0]        vram_word_o
);

logic [xreg_pkg::WORD_W-1:0]    rd_incr;
logic [xreg_pkg::WORD_W-1:0]    rd_addr;
logic [xreg_pkg::WORD_W-1:0]    wr_incr;
logic [xreg_pkg::WORD_W-1:0]    wr_addr;
logic [xreg_pkg::WORD_W-1:0]    rd_data;        // pre-read result
logic [xreg_pkg::BYTE_W-1:0]    data_even;      // high byte waiting for odd write
logic                           sel_data;
logic                           ack;

assign sel_data    = reg_sel_i[xreg_pkg::XM_DATA] | reg_sel_i[xreg_pkg::XM_DATA_2];
assign ack         = vram_sel_o & vram_ack_i;
assign vram_busy_o = vram_sel_o;

always_comb begin
    if (reg_sel_i[xreg_pkg::XM_RD_INCR])        vram_word_o = rd_incr;
    else if (reg_sel_i[xreg_pkg::XM_RD_ADDR])   vram_word_o = rd_addr;
    else if (reg_sel_i[xreg_pkg::XM_WR_INCR])   vram_word_o = wr_incr;
    else if (reg_sel_i[xreg_pkg::XM_WR_ADDR])   vram_word_o = wr_addr;
    else                                        vram_word_o = rd_data;
end

always_ff @(posedge clk) begin
    if (wr_even_i && sel_data) begin
        data_even <= byte_i;
    end
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        vram_sel_o  <= 1'b0;
        vram_wr_o   <= 1'b0;
        vram_addr_o <= '0;
        vram_data_o <= '0;
        rd_incr     <= '0;
        rd_addr     <= '0;
        wr_incr     <= '0;
        wr_addr     <= '0;
        rd_data     <= '0;
    end else begin
        if (ack) begin
            if (vram_wr_o) begin
                wr_addr     <= wr_addr + wr_incr;
            end else begin
                rd_data     <= vram_data_i;
                rd_addr     <= rd_addr + rd_incr;
            end
            vram_sel_o  <= 1'b0;
            vram_wr_o   <= 1'b0;
        end
        if (wr_even_i) begin
            if (reg_sel_i[xreg_pkg::XM_RD_INCR]) rd_incr[15:8] <= byte_i;
            if (reg_sel_i[xreg_pkg::XM_RD_ADDR]) rd_addr[15:8] <= byte_i;
            if (reg_sel_i[xreg_pkg::XM_WR_INCR]) wr_incr[15:8] <= byte_i;
            if (reg_sel_i[xreg_pkg::XM_WR_ADDR]) wr_addr[15:8] <= byte_i;
        end
        if (wr_odd_i) begin
            if (reg_sel_i[xreg_pkg::XM_RD_INCR]) rd_incr[7:0] <= byte_i;
            if (reg_sel_i[xreg_pkg::XM_WR_INCR]) wr_incr[7:0] <= byte_i;
            if (reg_sel_i[xreg_pkg::XM_WR_ADDR]) wr_addr[7:0] <= byte_i;
            if (reg_sel_i[xreg_pkg::XM_RD_ADDR]) begin
                rd_addr[7:0] <= byte_i;
                vram_sel_o  <= 1'b1;            // pre-read new address
                vram_wr_o   <= 1'b0;
                vram_addr_o <= {rd_addr[15:8], byte_i};
            end
            if (sel_data) begin
                vram_sel_o  <= 1'b1;
                vram_wr_o   <= 1'b1;
                vram_addr_o <= wr_addr;
                vram_data_o <= {data_even, byte_i};
            end
        end
        if (rd_odd_i && sel_data) begin
            vram_sel_o  <= 1'b1;                // fetch next word
            vram_wr_o   <= 1'b0;
            vram_addr_o <= rd_addr;
        end
    end
end

endmodule

`default_nettype wire

//--- xr_port.sv
// XR address registers and access sequencing
`default_nettype none
`timescale 1ns/100ps

module xr_port (
    input  wire logic                               clk,
    input  wire logic                               reset_i,
    input  wire logic [xreg_pkg::NUM_REGS-1:0]      reg_sel_i,
    input  wire logic                               wr_even_i,
    input  wire logic                               wr_odd_i,
    input  wire logic                               rd_odd_i,
    input  wire logic [xreg_pkg::BYTE_W-1:0]        byte_i,
    input  wire logic                               xr_ack_i,
    input  wire logic [xreg_pkg::WORD_W-1:0]        xr_data_i,
    output logic                                    xr_sel_o,
    output logic                                    xr_wr_o,
    output logic      [xreg_pkg::WORD_W-1:0]        xr_addr_o,
    output logic      [xreg_pkg::WORD_W-1:0]        xr_data_o,
    output logic                                    xr_busy_o,
    output logic      [xreg_pkg::WORD_W-1:0]        xr_word_o
);

logic [xreg_pkg::WORD_W-1:0]    rd_xaddr;
logic [xreg_pkg::WORD_W-1:0]    wr_xaddr;
logic [xreg_pkg::WORD_W-1:0]    xdata;          // pre-read result
logic [xreg_pkg::BYTE_W-1:0]    xdata_even;
logic                           sel_xdata;
logic                           ack;

assign sel_xdata = reg_sel_i[xreg_pkg::XM_XDATA];
assign ack       = xr_sel_o & xr_ack_i;
assign xr_busy_o = xr_sel_o;

always_comb begin
    if (reg_sel_i[xreg_pkg::XM_RD_XADDR])       xr_word_o = rd_xaddr;
    else if (reg_sel_i[xreg_pkg::XM_WR_XADDR])  xr_word_o = wr_xaddr;
    else                                        xr_word_o = xdata;
end

always_ff @(posedge clk) begin
    if (wr_even_i && sel_xdata) begin
        xdata_even <= byte_i;
    end
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        xr_sel_o  <= 1'b0;
        xr_wr_o   <= 1'b0;
        xr_addr_o <= '0;
        xr_data_o <= '0;
        rd_xaddr  <= '0;
        wr_xaddr  <= '0;
        xdata     <= '0;
    end else begin
        if (ack) begin
            if (xr_wr_o) begin
                wr_xaddr <= wr_xaddr + 1'b1;
            end else begin
                xdata    <= xr_data_i;
                rd_xaddr <= rd_xaddr + 1'b1;
            end
            xr_sel_o <= 1'b0;
            xr_wr_o  <= 1'b0;
        end
        if (wr_even_i) begin
            if (reg_sel_i[xreg_pkg::XM_RD_XADDR]) rd_xaddr[15:8] <= byte_i;
            if (reg_sel_i[xreg_pkg::XM_WR_XADDR]) wr_xaddr[15:8] <= byte_i;
        end
        if (wr_odd_i) begin
            if (reg_sel_i[xreg_pkg::XM_WR_XADDR]) wr_xaddr[7:0] <= byte_i;
            if (reg_sel_i[xreg_pkg::XM_RD_XADDR]) begin
                rd_xaddr[7:0] <= byte_i;
                xr_sel_o  <= 1'b1;              // pre-read
                xr_wr_o   <= 1'b0;
                xr_addr_o <= {rd_xaddr[15:8], byte_i};
            end
            if (sel_xdata) begin
                xr_sel_o  <= 1'b1;
                xr_wr_o   <= 1'b1;
                xr_addr_o <= wr_xaddr;
                xr_data_o <= {xdata_even, byte_i};
            end
        end
        if (rd_odd_i && sel_xdata) begin
            xr_sel_o  <= 1'b1;                  // next pre-read
            xr_wr_o   <= 1'b0;
            xr_addr_o <= rd_xaddr;
        end
    end
end

endmodule

`default_nettype wire

//--- tick_timer.sv
// Free-running tick timer
`default_nettype none
`timescale 1ns/100ps

module tick_timer (
    input  wire logic                               clk,
    input  wire logic                               reset_i,
    input  wire logic                               rd_even_i,
    input  wire logic [xreg_pkg::NUM_REGS-1:0]      reg_sel_i,
    output logic      [xreg_pkg::WORD_W-1:0]        timer_word_o
);

logic [xreg_pkg::TIMER_FRAC_W-1:0]  frac;       // clocks within a tick
logic [xreg_pkg::WORD_W-1:0]        ticks;
logic [xreg_pkg::BYTE_W-1:0]        low_latch;  // frozen by high byte read

always_ff @(posedge clk) begin
    if (reset_i) begin
        frac      <= '0;
        ticks     <= '0;
        low_latch <= '0;
    end else begin
        if (frac == xreg_pkg::TIMER_FRAC_W'(xreg_pkg::TIMER_DIV)) begin
            frac  <= '0;
            ticks <= ticks + 1'b1;              // TIMER_DIV+1 clocks per tick
        end else begin
            frac  <= frac + 1'b1;
        end
        if (rd_even_i && reg_sel_i[xreg_pkg::XM_TIMER]) begin
            low_latch <= ticks[7:0];
        end
    end
end

assign timer_word_o = {ticks[15:8], low_latch};

endmodule

`default_nettype wire

//--- reg_interface.sv
// Host register block top level
`default_nettype none
`timescale 1ns/100ps

module reg_interface (
    input  wire logic                               clk,
    input  wire logic                               reset_i,
    input  wire logic                               bus_write_strobe_i,
    input  wire logic                               bus_read_strobe_i,
    input  wire logic [xreg_pkg::REG_NUM_W-1:0]     bus_reg_num_i,
    input  wire logic                               bus_bytesel_i,
    input  wire logic [xreg_pkg::BYTE_W-1:0]        bus_data_i,
    output logic      [xreg_pkg::BYTE_W-1:0]        bus_data_o,
    output logic                                    vram_sel_o,
    output logic                                    vram_wr_o,
    output logic      [xreg_pkg::WORD_W-1:0]        vram_addr_o,
    output logic      [xreg_pkg::WORD_W-1:0]        vram_data_o,
    input  wire logic                               vram_ack_i,
    input  wire logic [xreg_pkg::WORD_W-1:0]        vram_data_i,
    output logic                                    xr_sel_o,
    output logic                                    xr_wr_o,
    output logic      [xreg_pkg::WORD_W-1:0]        xr_addr_o,
    output logic      [xreg_pkg::WORD_W-1:0]        xr_data_o,
    input  wire logic                               xr_ack_i,
    input  wire logic [xreg_pkg::WORD_W-1:0]        xr_data_i,
    output logic      [xreg_pkg::WRMASK_W-1:0]      wrmask_o,
    output logic      [xreg_pkg::INTR_W-1:0]        intr_mask_o,
    output logic      [xreg_pkg::INTR_W-1:0]        intr_clear_o,
    input  wire logic [xreg_pkg::INTR_W-1:0]        intr_status_i
);

logic [xreg_pkg::NUM_REGS-1:0]  reg_sel;        // one-hot register select
logic                           wr_even;
logic                           wr_odd;
logic                           rd_even;
logic                           rd_odd;
logic [xreg_pkg::BYTE_W-1:0]    bus_byte;
logic                           vram_busy;
logic                           xr_busy;
logic [xreg_pkg::WORD_W-1:0]    vram_word;
logic [xreg_pkg::WORD_W-1:0]    xr_word;
logic [xreg_pkg::WORD_W-1:0]    timer_word;

reg_ctrl u_reg_ctrl (
    .clk(clk), .reset_i(reset_i),
    .bus_write_strobe_i(bus_write_strobe_i), .bus_read_strobe_i(bus_read_strobe_i),
    .bus_reg_num_i(bus_reg_num_i), .bus_bytesel_i(bus_bytesel_i),
    .bus_data_i(bus_data_i),
    .vram_busy_i(vram_busy), .xr_busy_i(xr_busy),
    .vram_word_i(vram_word), .xr_word_i(xr_word), .timer_word_i(timer_word),
    .intr_status_i(intr_status_i),
    .reg_sel_o(reg_sel), .wr_even_o(wr_even), .wr_odd_o(wr_odd),
    .rd_even_o(rd_even), .rd_odd_o(rd_odd), .byte_o(bus_byte),
    .bus_data_o(bus_data_o), .wrmask_o(wrmask_o),
    .intr_mask_o(intr_mask_o), .intr_clear_o(intr_clear_o)
);

vram_port u_vram_port (
    .clk(clk), .reset_i(reset_i),
    .reg_sel_i(reg_sel), .wr_even_i(wr_even), .wr_odd_i(wr_odd), .rd_odd_i(rd_odd),
    .byte_i(bus_byte), .vram_ack_i(vram_ack_i), .vram_data_i(vram_data_i),
    .vram_sel_o(vram_sel_o), .vram_wr_o(vram_wr_o),
    .vram_addr_o(vram_addr_o), .vram_data_o(vram_data_o),
    .vram_busy_o(vram_busy), .vram_word_o(vram_word)
);

xr_port u_xr_port (
    .clk(clk), .reset_i(reset_i),
    .reg_sel_i(reg_sel), .wr_even_i(wr_even), .wr_odd_i(wr_odd), .rd_odd_i(rd_odd),
    .byte_i(bus_byte), .xr_ack_i(xr_ack_i), .xr_data_i(xr_data_i),
    .xr_sel_o(xr_sel_o), .xr_wr_o(xr_wr_o),
    .xr_addr_o(xr_addr_o), .xr_data_o(xr_data_o),
    .xr_busy_o(xr_busy), .xr_word_o(xr_word)
);

tick_timer u_tick_timer (
    .clk(clk), .reset_i(reset_i),
    .rd_even_i(rd_even), .reg_sel_i(reg_sel),
    .timer_word_o(timer_word)
);

endmodule

`default_nettype wire

//--- reg_interface_props.sv
// Register interface handshake properties
`default_nettype none
`timescale 1ns/100ps

module reg_interface_props (
    input  wire logic                               clk,
    input  wire logic                               reset_i,
    input  wire logic                               vram_sel_i,
    input  wire logic                               vram_wr_i,
    input  wire logic [xreg_pkg::WORD_W-1:0]        vram_addr_i,
    input  wire logic [xreg_pkg::WORD_W-1:0]        vram_wdata_i,
    input  wire logic                               vram_ack_i,
    input  wire logic                               xr_sel_i,
    input  wire logic                               xr_wr_i,
    input  wire logic [xreg_pkg::WORD_W-1:0]        xr_addr_i,
    input  wire logic [xreg_pkg::WORD_W-1:0]        xr_wdata_i,
    input  wire logic                               xr_ack_i,
    input  wire logic [xreg_pkg::INTR_W-1:0]        intr_clear_i,
    input  wire logic [xreg_pkg::INTR_W-1:0]        intr_mask_i
);

vram_hold: assert property (@(posedge clk) disable iff (reset_i)
    vram_sel_i && !vram_ack_i |=> vram_sel_i && $stable(vram_wr_i) &&
        $stable(vram_addr_i) && $stable(vram_wdata_i))
    else $error("vram request changed before ack");

xr_hold: assert property (@(posedge clk) disable iff (reset_i)
    xr_sel_i && !xr_ack_i |=> xr_sel_i && $stable(xr_wr_i) &&
        $stable(xr_addr_i) && $stable(xr_wdata_i))
    else $error("xr request changed before ack");

wr_needs_sel: assert property (@(posedge clk)
    (vram_wr_i |-> vram_sel_i) and (xr_wr_i |-> xr_sel_i))
    else $error("memory write without select");

clear_pulse: assert property (@(posedge clk) disable iff (reset_i)
    intr_clear_i != '0 |=> intr_clear_i == '0)
    else $error("intr_clear held longer than one cycle");

// everything idle on the edge after reset
reset_quiet: assert property (@(posedge clk)
    reset_i |=> !vram_sel_i && !vram_wr_i && !xr_sel_i && !xr_wr_i &&
        intr_clear_i == '0 && intr_mask_i == '0)
    else $error("outputs active after reset");

endmodule

bind reg_interface reg_interface_props u_props (
    .clk(clk), .reset_i(reset_i),
    .vram_sel_i(vram_sel_o), .vram_wr_i(vram_wr_o), .vram_addr_i(vram_addr_o),
    .vram_wdata_i(vram_data_o), .vram_ack_i(vram_ack_i),
    .xr_sel_i(xr_sel_o), .xr_wr_i(xr_wr_o), .xr_addr_i(xr_addr_o),
    .xr_wdata_i(xr_data_o), .xr_ack_i(xr_ack_i),
    .intr_clear_i(intr_clear_o), .intr_mask_i(intr_mask_o)
);

`default_nettype wire

//--- tb_reg_interface.sv
// Register interface testbench
`default_nettype none
`timescale 1ns/100ps

module tb_reg_interface;

localparam int          CLK_PERIOD = 100;
localparam int          NUM_WORDS  = 8;         // words per memory burst
localparam int          POLL_LIMIT = 64;        // mem_wait polls before giving up
// timer test needs about 1400 cycles and each memory test a few hundred
localparam int          WATCHDOG_CYCLES = 20000;
localparam logic [31:0] SEED = 32'h8b4f_75c8;

logic                               clk;
logic                               reset_i;
logic                               bus_write_strobe_i;
logic                               bus_read_strobe_i;
logic [xreg_pkg::REG_NUM_W-1:0]     bus_reg_num_i;
logic                               bus_bytesel_i;
logic [xreg_pkg::BYTE_W-1:0]        bus_data_i;
logic [xreg_pkg::BYTE_W-1:0]        bus_data_o;
logic                               vram_sel_o;
logic                               vram_wr_o;
logic [xreg_pkg::WORD_W-1:0]        vram_addr_o;
logic [xreg_pkg::WORD_W-1:0]        vram_data_o;
logic                               vram_ack_i;
logic [xreg_pkg::WORD_W-1:0]        vram_data_i;
logic                               xr_sel_o;
logic                               xr_wr_o;
logic [xreg_pkg::WORD_W-1:0]        xr_addr_o;
logic [xreg_pkg::WORD_W-1:0]        xr_data_o;
logic                               xr_ack_i;
logic [xreg_pkg::WORD_W-1:0]        xr_data_i;
logic [xreg_pkg::WRMASK_W-1:0]      wrmask_o;
logic [xreg_pkg::INTR_W-1:0]        intr_mask_o;
logic [xreg_pkg::INTR_W-1:0]        intr_clear_o;
logic [xreg_pkg::INTR_W-1:0]        intr_status_i;

logic [xreg_pkg::WORD_W-1:0]        vram_mem [0:65535];
logic [xreg_pkg::WORD_W-1:0]        xr_mem [0:65535];
logic [31:0]                        test_rng;
logic [31:0]                        mem_rng;       // ack delays only
logic [1:0]                         vram_delay;
logic [1:0]                         xr_delay;
int                                 errors;
int                                 checks;
int                                 err_start;

reg_interface DUT (.*);

initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
end

function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
endfunction

// memory models answering after 0 to 3 idle cycles
always @(negedge clk) begin
    if (vram_ack_i) begin
        vram_ack_i <= 1'b0;                     // sel dropped on the acked edge
    end else if (vram_sel_o) begin
        if (vram_delay == 2'd0) begin
            if (vram_wr_o) begin
                vram_mem[vram_addr_o] = vram_data_o;
            end else begin
                vram_data_i <= vram_mem[vram_addr_o];
            end
            vram_ack_i <= 1'b1;
            mem_rng = xorshift(mem_rng);
            vram_delay <= mem_rng[1:0];
        end else begin
            vram_delay <= vram_delay - 2'd1;
        end
    end
    if (xr_ack_i) begin
        xr_ack_i <= 1'b0;
    end else if (xr_sel_o) begin
        if (xr_delay == 2'd0) begin
            if (xr_wr_o) begin
                xr_mem[xr_addr_o] = xr_data_o;
            end else begin
                xr_data_i <= xr_mem[xr_addr_o];
            end
            xr_ack_i <= 1'b1;
            mem_rng = xorshift(mem_rng);
            xr_delay <= mem_rng[3:2];
        end else begin
            xr_delay <= xr_delay - 2'd1;
        end
    end
end

task automatic draw_word(output logic [xreg_pkg::WORD_W-1:0] w);
    test_rng = xorshift(test_rng);
    w = test_rng[15:0];
endtask

task automatic write_byte(input logic [3:0] num, input logic sel, input logic [7:0] data);
    @(negedge clk);
    bus_write_strobe_i = 1'b1;
    bus_reg_num_i = num;
    bus_bytesel_i = sel;
    bus_data_i = data;
    @(negedge clk);
    bus_write_strobe_i = 1'b0;
endtask

task automatic read_byte(input logic [3:0] num, input logic sel, output logic [7:0] data);
    @(negedge clk);
    bus_read_strobe_i = 1'b1;
    bus_reg_num_i = num;
    bus_bytesel_i = sel;
    #(CLK_PERIOD/10);
    data = bus_data_o;                          // sampled mid-cycle once settled
    @(negedge clk);
    bus_read_strobe_i = 1'b0;
endtask

task automatic write_word(input logic [3:0] num, input logic [15:0] w);
    write_byte(num, 1'b0, w[15:8]);
    write_byte(num, 1'b1, w[7:0]);
endtask

task automatic read_word(input logic [3:0] num, output logic [15:0] w);
    read_byte(num, 1'b0, w[15:8]);
    read_byte(num, 1'b1, w[7:0]);
endtask

task automatic wait_mem_idle();
    logic [7:0] status;
    int         polls;
    polls = 0;
    read_byte(xreg_pkg::XM_SYS_CTRL, 1'b0, status);
    while (status[7] && polls < POLL_LIMIT) begin  // mem_wait is bit 15
        read_byte(xreg_pkg::XM_SYS_CTRL, 1'b0, status);
        polls++;
    end
    if (status[7]) begin
        errors++;
        $display("ERROR at %0t: memory access still pending after %0d polls", $time, polls);
    end
endtask

task automatic check_word(input string name, input logic [xreg_pkg::WORD_W-1:0] got,
                          input logic [xreg_pkg::WORD_W-1:0] exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("MISMATCH at %0t: %s got %04h expected %04h", $time, name, got, exp);
    end
endtask

task automatic check_byte(input string name, input logic [xreg_pkg::BYTE_W-1:0] got,
                          input logic [xreg_pkg::BYTE_W-1:0] exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("MISMATCH at %0t: %s got %02h expected %02h", $time, name, got, exp);
    end
endtask

task automatic check_nibble(input string name, input logic [xreg_pkg::INTR_W-1:0] got,
                            input logic [xreg_pkg::INTR_W-1:0] exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("MISMATCH at %0t: %s got %01h expected %01h", $time, name, got, exp);
    end
endtask

task automatic report_test(input string name, input int err_before);
    if (errors == err_before) begin
        $display("%s: ok", name);
    end else begin
        $display("%s: %0d errors", name, errors - err_before);
    end
endtask

task automatic reset_values();
    logic [3:0]  num;
    logic [15:0] w;
    checks++;
    if (vram_sel_o || xr_sel_o) begin
        errors++;
        $display("ERROR at %0t: memory select is high after reset", $time);
    end
    check_nibble("intr_mask_o", intr_mask_o, 4'h0);
    check_nibble("intr_clear_o", intr_clear_o, 4'h0);
    check_nibble("wrmask_o", wrmask_o, 4'hF);
    for (int n = 0; n < xreg_pkg::NUM_REGS; n++) begin
        num = 4'(n);
        // timer runs and DATA and XDATA reads start pre-reads
        if (num != xreg_pkg::XM_TIMER && num != xreg_pkg::XM_DATA &&
            num != xreg_pkg::XM_DATA_2 && num != xreg_pkg::XM_XDATA) begin
            read_word(num, w);
            check_word($sformatf("reg %0d", n), w,
                       (num == xreg_pkg::XM_SYS_CTRL) ? 16'h000F : 16'h0000);
        end
    end
    read_word(xreg_pkg::XM_DATA, w);
    check_word("DATA", w, 16'h0000);
    read_word(xreg_pkg::XM_XDATA, w);
    check_word("XDATA", w, 16'h0000);
    wait_mem_idle();
    write_byte(xreg_pkg::XM_SYS_CTRL, 1'b1, 8'hA5);
    check_nibble("wrmask_o", wrmask_o, 4'h5);
    read_word(xreg_pkg::XM_SYS_CTRL, w);
    check_word("SYS_CTRL", w, 16'h0005);
endtask

task automatic vram_write_run();
    logic [15:0] incr;
    logic [15:0] addr;
    logic [15:0] w;
    logic [15:0] words [NUM_WORDS];
    draw_word(incr);
    incr[0] = 1'b1;                             // odd step so no address repeats
    draw_word(addr);
    write_word(xreg_pkg::XM_WR_INCR, incr);
    write_word(xreg_pkg::XM_WR_ADDR, addr);
    for (int k = 0; k < NUM_WORDS; k++) begin
        draw_word(words[k]);
        write_word((k % 2 == 1) ? xreg_pkg::XM_DATA_2 : xreg_pkg::XM_DATA, words[k]);
        wait_mem_idle();
    end
    for (int k = 0; k < NUM_WORDS; k++) begin
        check_word($sformatf("vram[%04h]", addr), vram_mem[addr], words[k]);
        addr = addr + incr;
    end
    read_word(xreg_pkg::XM_WR_ADDR, w);
    check_word("WR_ADDR", w, addr);
endtask

task automatic vram_read_run();
    logic [15:0] incr;
    logic [15:0] base;
    logic [15:0] addr;
    logic [15:0] w;
    logic [15:0] words [NUM_WORDS+1];
    draw_word(incr);
    incr[0] = 1'b1;
    draw_word(base);
    addr = base;
    for (int k = 0; k <= NUM_WORDS; k++) begin  // one extra for the last pre-read
        draw_word(words[k]);
        vram_mem[addr] = words[k];
        addr = addr + incr;
    end
    write_word(xreg_pkg::XM_RD_INCR, incr);
    write_word(xreg_pkg::XM_RD_ADDR, base);
    wait_mem_idle();
    for (int k = 0; k < NUM_WORDS; k++) begin
        read_word((k % 2 == 1) ? xreg_pkg::XM_DATA_2 : xreg_pkg::XM_DATA, w);
        check_word($sformatf("DATA read %0d", k), w, words[k]);
        wait_mem_idle();
    end
    read_word(xreg_pkg::XM_RD_ADDR, w);
    check_word("RD_ADDR", w, addr);
endtask

task automatic xr_access();
    logic [15:0] base;
    logic [15:0] addr;
    logic [15:0] w;
    logic [15:0] words [NUM_WORDS];
    draw_word(base);
    write_word(xreg_pkg::XM_WR_XADDR, base);
    for (int k = 0; k < NUM_WORDS; k++) begin
        draw_word(words[k]);
        write_word(xreg_pkg::XM_XDATA, words[k]);
        wait_mem_idle();
    end
    addr = base;
    for (int k = 0; k < NUM_WORDS; k++) begin
        check_word($sformatf("xr[%04h]", addr), xr_mem[addr], words[k]);
        addr = addr + 16'd1;
    end
    read_word(xreg_pkg::XM_WR_XADDR, w);
    check_word("WR_XADDR", w, addr);
    write_word(xreg_pkg::XM_RD_XADDR, base);
    wait_mem_idle();
    for (int k = 0; k < NUM_WORDS; k++) begin
        read_word(xreg_pkg::XM_XDATA, w);
        check_word($sformatf("XDATA read %0d", k), w, words[k]);
        wait_mem_idle();
    end
    read_word(xreg_pkg::XM_RD_XADDR, w);
    check_word("RD_XADDR", w, addr + 16'd1);     // includes the trailing pre-read
endtask

task automatic timer_count();
    logic [15:0] t0;
    logic [15:0] t1;
    logic [15:0] diff;
    logic [7:0]  b;
    read_word(xreg_pkg::XM_TIMER, t0);
    repeat (10 * (xreg_pkg::TIMER_DIV + 1)) @(negedge clk);
    read_word(xreg_pkg::XM_TIMER, t1);
    diff = t1 - t0;
    checks++;
    if (diff < 16'd9 || diff > 16'd11) begin
        errors++;
        $display("ERROR at %0t: timer moved %0d ticks over ten tick periods", $time, diff);
    end
    for (int i = 0; i < 3; i++) begin
        repeat (xreg_pkg::TIMER_DIV + 1) @(negedge clk);
        read_byte(xreg_pkg::XM_TIMER, 1'b1, b);
        check_byte("TIMER low byte", b, t1[7:0]);
    end
endtask

task automatic interrupt_ctrl();
    logic [15:0] r;
    logic [15:0] w;
    logic [3:0]  mask;
    logic [3:0]  clear;
    logic [3:0]  status;
    draw_word(r);
    status = r[3:0];
    mask = r[7:4];
    clear = r[11:8] | 4'h1;
    @(negedge clk);
    intr_status_i = status;
    write_byte(xreg_pkg::XM_INT_CTRL, 1'b0, {r[15:12], mask});
    check_nibble("intr_mask_o", intr_mask_o, mask);
    write_byte(xreg_pkg::XM_INT_CTRL, 1'b1, {r[15:12], clear});
    check_nibble("intr_clear_o", intr_clear_o, clear);
    @(negedge clk);
    check_nibble("intr_clear_o", intr_clear_o, 4'h0);
    read_word(xreg_pkg::XM_INT_CTRL, w);
    check_word("INT_CTRL", w, {4'h0, mask, 4'h0, status});
endtask

initial begin
    reset_i = 1'b1;
    bus_write_strobe_i = 1'b0;
    bus_read_strobe_i = 1'b0;
    bus_reg_num_i = '0;
    bus_bytesel_i = 1'b0;
    bus_data_i = '0;
    vram_ack_i = 1'b0;
    vram_data_i = '0;
    xr_ack_i = 1'b0;
    xr_data_i = '0;
    intr_status_i = '0;
    test_rng = SEED;
    mem_rng = xorshift(SEED);
    vram_delay = 2'd0;
    xr_delay = 2'd0;
    errors = 0;
    checks = 0;
    for (int a = 0; a < 65536; a++) begin
        vram_mem[a] = 16'(a) ^ 16'h3c5a;
        xr_mem[a] = ~16'(a);
    end
    repeat (16) @(negedge clk);
    reset_i = 1'b0;
    err_start = errors;
    reset_values();
    report_test("reset values", err_start);
    err_start = errors;
    vram_write_run();
    report_test("vram writes", err_start);
    err_start = errors;
    vram_read_run();
    report_test("vram reads", err_start);
    err_start = errors;
    xr_access();
    report_test("xr access", err_start);
    err_start = errors;
    timer_count();
    report_test("timer", err_start);
    err_start = errors;
    interrupt_ctrl();
    report_test("interrupts", err_start);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
        $display("Test completed successfully");
    end else begin
        $display("Test failed");
    end
    $finish;
end

initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Test failed");
    $finish;
end

endmodule

`default_nettype wire

//--- sim.f
xreg_pkg.sv
reg_ctrl.sv
vram_port.sv
xr_port.sv
tick_timer.sv
reg_interface.sv
reg_interface_props.sv
tb_reg_interface.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the register interface simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_reg_interface -f sim.f
./obj_dir/Vtb_reg_interface | tee sim.log

if grep -q "Test completed successfully" sim.log; then
    echo "simulation passed"
else
    echo "simulation FAILED"
    exit 1
fi
